//--- common/game_pkg.sv
package game_pkg;

	typedef logic [1:0] level_t;      // 0..3, saturates at 3
	typedef logic [1:0] speed_t;      // object speed step
	typedef logic [1:0] life_t;       // lives left, 3 down to 1
	typedef logic [1:0] bird_mask_t;  // one bit per bird

	typedef struct packed {
		speed_t     tree_speed;
		speed_t     bird_speed;
		logic [2:0] trees;  // trees launched over the level
		bird_mask_t birds;  // birds launched at level start
	} level_cfg_t;

	// settings of one level
	function automatic level_cfg_t level_config(input level_t level);
		level_cfg_t cfg;
		cfg.tree_speed = (level == 2'd3) ? 2'd3 : level + 2'd1;
		cfg.bird_speed = level;
		cfg.trees      = {1'b0, level} + 3'd2;
		cfg.birds      = level[1] ? 2'b11 : 2'b01;  // second bird from level 2
		return cfg;
	endfunction

endpackage

//--- common/spawn_pkg.sv
package spawn_pkg;

	// one frame worth of launches
	typedef struct packed {
		logic       shot;
		logic       tree;
		logic [1:0] birds;  // same layout as the bird mask
	} spawn_req_t;

	typedef logic [2:0] shot_slot_t;  // eight shot slots
	typedef logic [2:0] tree_slot_t;  // eight tree slots

endpackage

//--- game_controller/level_fsm.sv
`timescale 1ns/100ps

module level_fsm (
	input  logic                  clk,
	input  logic                  resetN,
	input  logic                  level_up,
	output game_pkg::level_t      level,
	output game_pkg::level_cfg_t  cfg
);
	import game_pkg::*;

	level_t level_next;

	// saturating step to the next level
	always_comb begin
		level_next = level;
		if (level_up && (level != 2'd3))
			level_next = level + 2'd1;
	end

	// cfg tracks the level in the same cycle it changes
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			level <= 2'd0;
			cfg   <= level_config(2'd0);
		end
		else begin
			level <= level_next;
			cfg   <= level_config(level_next);
		end
	end

	a_level_up_pulse: assert property (@(posedge clk) disable iff (!resetN)
		level_up |=> !level_up);

endmodule

//--- game_controller/game_controller.sv
`timescale 1ns/100ps

module game_controller #(
	parameter int COOLDOWN_FRAMES = 4,
	parameter int TREE_INTERVAL   = 6,
	parameter int RED_FRAMES      = 8,
	parameter int LEVEL_DELAY     = 4
) (
	input  logic                  clk,
	input  logic                  resetN,
	input  logic                  start_of_frame,
	input  logic                  shoot,
	input  logic                  hit,           // single pulse per frame
	input  game_pkg::bird_mask_t  bird_alive,
	input  logic                  req_ready,
	output spawn_pkg::spawn_req_t req,
	output logic                  req_valid,
	output game_pkg::speed_t      tree_speed,
	output game_pkg::speed_t      bird_speed,
	output game_pkg::level_t      level,
	output game_pkg::life_t       lives,
	output logic                  player_red,
	output logic                  player_active
);
	import game_pkg::*;
	import spawn_pkg::*;

	localparam int CD_W  = $clog2(COOLDOWN_FRAMES + 1);
	localparam int TT_W  = $clog2(TREE_INTERVAL + 1);
	localparam int RED_W = $clog2(RED_FRAMES + 1);
	localparam int LD_W  = $clog2(LEVEL_DELAY + 1);

	localparam logic [CD_W-1:0]  CD_RELOAD  = CD_W'(COOLDOWN_FRAMES - 1);
	localparam logic [TT_W-1:0]  TREE_LAST  = TT_W'(TREE_INTERVAL - 1);
	localparam logic [RED_W-1:0] RED_LOAD   = RED_W'(RED_FRAMES);
	localparam logic [LD_W-1:0]  DELAY_LOAD = LD_W'(LEVEL_DELAY);

	logic [CD_W-1:0]  cooldown;    // frames until next shot
	logic [TT_W-1:0]  tree_timer;
	logic [RED_W-1:0] red_cnt;     // invincibility frames left
	logic [LD_W-1:0]  delay_cnt;   // frames until next level start
	logic [2:0]       trees_left;
	logic             start_pending;
	logic             birds_out;   // level birds in flight
	logic             level_up;
	level_cfg_t       cfg;

	logic       busy;
	logic       hit_taken;
	logic       fatal_hit;
	logic       can_launch;
	logic       start_now;
	logic       fire_shot;
	logic       fire_tree;
	logic       fire_birds;
	logic       tree_tick;
	spawn_req_t launch_req;

	level_fsm level_fsm_i (
		.clk      (clk),
		.resetN   (resetN),
		.level_up (level_up),
		.level    (level),
		.cfg      (cfg)
	);

	assign tree_speed = cfg.tree_speed;
	assign bird_speed = cfg.bird_speed;
	assign player_red = (red_cnt != '0);

	// a held request defers every launch of the frame
	assign busy       = req_valid && !req_ready;
	assign hit_taken  = hit && (red_cnt == '0) && player_active;
	assign fatal_hit  = hit_taken && (lives == 2'd1);
	assign can_launch = player_active && !fatal_hit && !busy;
	assign start_now  = start_pending || (delay_cnt == LD_W'(1));
	assign fire_shot  = can_launch && shoot && (cooldown == '0);
	assign fire_tree  = can_launch && (trees_left != '0) && (tree_timer == TREE_LAST);
	assign fire_birds = can_launch && start_now;
	assign tree_tick  = !busy && player_active && (trees_left != '0);

	always_comb begin
		launch_req.shot  = fire_shot;
		launch_req.tree  = fire_tree;
		launch_req.birds = fire_birds ? cfg.birds : 2'b00;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cooldown      <= '0;
			tree_timer    <= '0;
			red_cnt       <= '0;
			delay_cnt     <= '0;
			trees_left    <= '0;
			start_pending <= 1'b1;  // first frame starts level 0
			birds_out     <= 1'b0;
			level_up      <= 1'b0;
			lives         <= 2'd3;
			player_active <= 1'b1;
			req           <= '0;
			req_valid     <= 1'b0;
		end
		else begin
			level_up <= 1'b0;
			if (req_valid && req_ready)
				req_valid <= 1'b0;  // taken by the queue
			if (start_of_frame) begin
				if (red_cnt != '0)
					red_cnt <= red_cnt - 1'b1;
				if (delay_cnt != '0)
					delay_cnt <= delay_cnt - 1'b1;
				if (!busy && (cooldown != '0))
					cooldown <= cooldown - 1'b1;
				if (fire_shot)
					cooldown <= CD_RELOAD;
				if (tree_tick)
					tree_timer <= (tree_timer == TREE_LAST) ? '0 : tree_timer + 1'b1;
				if (fire_tree)
					trees_left <= trees_left - 3'd1;
				if (start_now)
					start_pending <= !fire_birds;  // keep waiting if deferred
				if (fire_birds) begin
					trees_left <= cfg.trees;
					tree_timer <= '0;
					birds_out  <= 1'b1;
				end
				if (hit_taken) begin
					if (fatal_hit)
						player_active <= 1'b0;  // game over
					else begin
						lives   <= lives - 2'd1;
						red_cnt <= RED_LOAD;
					end
				end
				if (birds_out && (bird_alive == 2'b00)) begin  // level cleared
					level_up  <= 1'b1;
					birds_out <= 1'b0;
					delay_cnt <= DELAY_LOAD;
				end
				if (fire_shot || fire_tree || fire_birds) begin
					req       <= launch_req;
					req_valid <= 1'b1;
				end
			end
		end
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!resetN)
		req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

//--- design/spawn_queue.sv
`timescale 1ns/100ps

module spawn_queue (
	input  logic                  clk,
	input  logic                  resetN,
	input  spawn_pkg::spawn_req_t req,
	input  logic                  req_valid,
	input  logic                  head_ready,
	output logic                  req_ready,
	output spawn_pkg::spawn_req_t head,
	output logic                  head_valid
);
	import spawn_pkg::*;

	localparam int DEPTH = 4;

	spawn_req_t mem [DEPTH];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [2:0] count;  // entries held, 0..4
	logic       push;
	logic       pop;

	assign req_ready  = (count != 3'(DEPTH));
	assign head_valid = (count != 3'd0);
	assign head       = mem[rd_ptr];
	assign push       = req_valid && req_ready;
	assign pop        = head_valid && head_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= req;
	end

	// pointers wrap on their own at depth 4
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			wr_ptr <= 2'd0;
			rd_ptr <= 2'd0;
			count  <= 3'd0;
		end
		else begin
			if (push)
				wr_ptr <= wr_ptr + 2'd1;
			if (pop)
				rd_ptr <= rd_ptr + 2'd1;
			case ({push, pop})
				2'b10:   count <= count + 3'd1;
				2'b01:   count <= count - 3'd1;
				default: count <= count;  // none, or both at once
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!resetN)
		req_valid && (count == 3'(DEPTH)) && !pop |=> $stable(wr_ptr) && (count == 3'(DEPTH)));
	a_no_underflow: assert property (@(posedge clk) disable iff (!resetN)
		(count == 3'd0) |=> $stable(rd_ptr));

endmodule

//--- design/slot_allocator.sv
`timescale 1ns/100ps

module slot_allocator #(
	parameter int MAX_SHOTS = 8,
	parameter int MAX_TREES = 8
) (
	input  logic                  clk,
	input  logic                  resetN,
	input  spawn_pkg::spawn_req_t head,
	input  logic                  head_valid,
	input  logic                  deploy_ready,
	output logic                  head_ready,
	output logic [MAX_SHOTS-1:0]  deploy_shot,
	output logic [MAX_TREES-1:0]  deploy_tree,
	output game_pkg::bird_mask_t  deploy_bird
);
	import spawn_pkg::*;

	localparam shot_slot_t SHOT_LAST = shot_slot_t'(MAX_SHOTS - 1);
	localparam tree_slot_t TREE_LAST = tree_slot_t'(MAX_TREES - 1);

	shot_slot_t shot_ptr;  // next free shot slot
	tree_slot_t tree_ptr;
	logic       take;

	assign head_ready = deploy_ready;  // renderer decides
	assign take       = head_valid && deploy_ready;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			shot_ptr    <= '0;
			tree_ptr    <= '0;
			deploy_shot <= '0;
			deploy_tree <= '0;
			deploy_bird <= 2'b00;
		end
		else begin
			deploy_shot <= '0;  // pulses last one cycle
			deploy_tree <= '0;
			deploy_bird <= 2'b00;
			if (take) begin
				deploy_shot[shot_ptr] <= head.shot;
				deploy_tree[tree_ptr] <= head.tree;
				deploy_bird           <= head.birds;
				if (head.shot)
					shot_ptr <= (shot_ptr == SHOT_LAST) ? '0 : shot_ptr + 1'b1;
				if (head.tree)
					tree_ptr <= (tree_ptr == TREE_LAST) ? '0 : tree_ptr + 1'b1;
			end
		end
	end

	a_onehot: assert property (@(posedge clk) disable iff (!resetN)
		$onehot0(deploy_shot) && $onehot0(deploy_tree));

endmodule

//--- design/game_top.sv
`timescale 1ns/100ps

module game_top #(
	parameter int MAX_SHOTS       = 8,
	parameter int MAX_TREES       = 8,
	parameter int COOLDOWN_FRAMES = 4,
	parameter int TREE_INTERVAL   = 6,
	parameter int RED_FRAMES      = 8,
	parameter int LEVEL_DELAY     = 4
) (
	input  logic                  clk,
	input  logic                  resetN,
	input  logic                  start_of_frame,
	input  logic                  shoot,
	input  game_pkg::bird_mask_t  bird_alive,
	input  logic                  hit,
	input  logic                  deploy_ready,
	output game_pkg::speed_t      tree_speed,
	output game_pkg::speed_t      bird_speed,
	output logic [MAX_SHOTS-1:0]  deploy_shot,
	output logic [MAX_TREES-1:0]  deploy_tree,
	output game_pkg::bird_mask_t  deploy_bird,
	output logic                  player_red,
	output logic                  player_active,
	output game_pkg::life_t       lives,
	output game_pkg::level_t      level
);
	import spawn_pkg::*;

	spawn_req_t req;
	spawn_req_t head;
	logic       req_valid;
	logic       req_ready;
	logic       head_valid;
	logic       head_ready;

	game_controller #(
		.COOLDOWN_FRAMES (COOLDOWN_FRAMES),
		.TREE_INTERVAL   (TREE_INTERVAL),
		.RED_FRAMES      (RED_FRAMES),
		.LEVEL_DELAY     (LEVEL_DELAY)
	) game_controller_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.shoot          (shoot),
		.hit            (hit),
		.bird_alive     (bird_alive),
		.req_ready      (req_ready),
		.req            (req),
		.req_valid      (req_valid),
		.tree_speed     (tree_speed),
		.bird_speed     (bird_speed),
		.level          (level),
		.lives          (lives),
		.player_red     (player_red),
		.player_active  (player_active)
	);

	spawn_queue spawn_queue_i (
		.clk        (clk),
		.resetN     (resetN),
		.req        (req),
		.req_valid  (req_valid),
		.head_ready (head_ready),
		.req_ready  (req_ready),
		.head       (head),
		.head_valid (head_valid)
	);

	slot_allocator #(
		.MAX_SHOTS (MAX_SHOTS),
		.MAX_TREES (MAX_TREES)
	) slot_allocator_i (
		.clk          (clk),
		.resetN       (resetN),
		.head         (head),
		.head_valid   (head_valid),
		.deploy_ready (deploy_ready),
		.head_ready   (head_ready),
		.deploy_shot  (deploy_shot),
		.deploy_tree  (deploy_tree),
		.deploy_bird  (deploy_bird)
	);

endmodule

//--- testbench/game_tb.sv
`timescale 1ns/100ps

module game_tb;
	import game_pkg::*;

	localparam int MAX_SHOTS       = 8;
	localparam int MAX_TREES       = 8;
	localparam int COOLDOWN_FRAMES = 4;
	localparam int TREE_INTERVAL   = 6;
	localparam int RED_FRAMES      = 8;
	localparam int LEVEL_DELAY     = 4;
	localparam int TIMEOUT_CYCLES  = 6000;  // ~155 frames of tests plus margin

	logic                 clk;
	logic                 resetN;
	logic                 sof = 1'b0;
	logic                 hit = 1'b0;
	logic                 shoot;
	logic                 deploy_ready;
	bird_mask_t           bird_alive = 2'b00;
	speed_t               tree_speed;
	speed_t               bird_speed;
	logic [MAX_SHOTS-1:0] deploy_shot;
	logic [MAX_TREES-1:0] deploy_tree;
	bird_mask_t           deploy_bird;
	logic                 player_red;
	logic                 player_active;
	life_t                lives;
	level_t               level;

	int cycles = 0;
	int frame_phase = 0;
	logic hit_req;     // hit on the next frame pulse
	logic kill_birds;  // player shoots every bird down
	logic bp_mode;     // renderer stalls at random
	int errors = 0;
	int err_mark = 0;
	int tests = 0;
	int passed = 0;

	// reference model state
	life_t  m_lives;
	level_t m_level;
	logic   m_active, m_lvl_up, m_birds_out, m_pending;
	int     m_red, m_delay, m_cool, m_trees, m_tree_wait, m_frame_no;
	int     m_shot_slot, m_tree_slot;
	int     m_shot_reqs, m_shot_deps, m_tree_reqs, m_tree_deps, m_bird_reqs, m_bird_deps;
	logic   hit_taken, launch_ok, shot_due, tree_due, start_due, first_frame;

	game_top game_top_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (sof),
		.shoot          (shoot),
		.bird_alive     (bird_alive),
		.hit            (hit),
		.deploy_ready   (deploy_ready),
		.tree_speed     (tree_speed),
		.bird_speed     (bird_speed),
		.deploy_shot    (deploy_shot),
		.deploy_tree    (deploy_tree),
		.deploy_bird    (deploy_bird),
		.player_red     (player_red),
		.player_active  (player_active),
		.lives          (lives),
		.level          (level)
	);

	function automatic speed_t tree_speed_of(input level_t l);
		int s;
		s = int'(l) + 1;
		if (s > 3)
			s = 3;
		return speed_t'(s);
	endfunction

	function automatic int tree_count_of(input level_t l);
		return int'(l) + 2;
	endfunction

	function automatic bird_mask_t bird_mask_of(input level_t l);
		return (l >= 2'd2) ? 2'b11 : 2'b01;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic report_fail(input string msg);
		$display("Fail %0t: %s", $time, msg);
		errors++;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// frame pulse every 16 cycles, run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		frame_phase <= (frame_phase == 15) ? 0 : frame_phase + 1;
		sof <= (frame_phase == 15);
		hit <= (frame_phase == 15) && hit_req;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// birds in play are the last deployed ones
	always @(posedge clk) begin
		if (|deploy_bird)
			bird_alive <= deploy_bird;
		else if (kill_birds)
			bird_alive <= 2'b00;
	end

	always_comb begin
		hit_taken   = hit && (m_red == 0) && m_active;
		launch_ok   = m_active && !(hit_taken && (m_lives == 2'd1));
		shot_due    = sof && launch_ok && shoot && (m_cool == 0);
		tree_due    = sof && launch_ok && (m_trees != 0) && (m_tree_wait == 1);
		start_due   = sof && launch_ok && (m_pending || (m_delay == 1));
		first_frame = sof && (m_frame_no == 0);
	end

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			m_lives <= 2'd3;
			m_level <= 2'd0;
			m_active <= 1'b1;
			m_lvl_up <= 1'b0;
			m_birds_out <= 1'b0;
			m_pending <= 1'b1;  // level 0 starts on the first frame
			m_red <= 0;
			m_delay <= 0;
			m_cool <= 0;
			m_trees <= 0;
			m_tree_wait <= 0;
			m_frame_no <= 0;
			m_shot_slot <= 0;
			m_tree_slot <= 0;
			m_shot_reqs <= 0;
			m_shot_deps <= 0;
			m_tree_reqs <= 0;
			m_tree_deps <= 0;
			m_bird_reqs <= 0;
			m_bird_deps <= 0;
		end
		else begin
			m_lvl_up <= 1'b0;
			if (m_lvl_up && (m_level != 2'd3))
				m_level <= m_level + 2'd1;
			if (sof) begin
				m_frame_no <= m_frame_no + 1;
				if (m_red != 0)
					m_red <= m_red - 1;
				if (m_delay != 0)
					m_delay <= m_delay - 1;
				if (shot_due)
					m_cool <= COOLDOWN_FRAMES - 1;
				else if (m_cool != 0)
					m_cool <= m_cool - 1;
				if (m_active && (m_trees != 0))
					m_tree_wait <= (m_tree_wait == 1) ? TREE_INTERVAL : m_tree_wait - 1;
				if (tree_due)
					m_trees <= m_trees - 1;
				if (m_pending || (m_delay == 1))
					m_pending <= !launch_ok;
				if (start_due) begin
					m_trees <= tree_count_of(m_level);
					m_tree_wait <= TREE_INTERVAL;
				end
				if (hit_taken && (m_lives == 2'd1))
					m_active <= 1'b0;
				else if (hit_taken) begin
					m_lives <= m_lives - 2'd1;
					m_red <= RED_FRAMES;
				end
				if (m_birds_out && (bird_alive == 2'b00)) begin  // level cleared
					m_lvl_up <= 1'b1;
					m_birds_out <= 1'b0;
					m_delay <= LEVEL_DELAY;
				end
			end
			if (shot_due)
				m_shot_reqs <= m_shot_reqs + 1;
			if (tree_due)
				m_tree_reqs <= m_tree_reqs + 1;
			if (start_due)
				m_bird_reqs <= m_bird_reqs + 1;
			if (|deploy_shot) begin
				m_shot_deps <= m_shot_deps + 1;
				m_shot_slot <= (m_shot_slot == MAX_SHOTS - 1) ? 0 : m_shot_slot + 1;
			end
			if (|deploy_tree) begin
				m_tree_deps <= m_tree_deps + 1;
				m_tree_slot <= (m_tree_slot == MAX_TREES - 1) ? 0 : m_tree_slot + 1;
			end
			if (|deploy_bird) begin
				m_bird_deps <= m_bird_deps + 1;
				m_birds_out <= 1'b1;
			end
		end
	end

	a_reset_state: assert property (@(posedge clk) $rose(resetN) |-> player_active
		&& lives == 2'd3 && level == 2'd0 && !player_red
		&& deploy_shot == '0 && deploy_tree == '0 && deploy_bird == 2'b00)
		else report_fail("outputs not at their reset values");
	a_lives: assert property (@(posedge clk) disable iff (!resetN) lives == m_lives)
		else report_fail("lives differ from the model");
	a_red: assert property (@(posedge clk) disable iff (!resetN) player_red == (m_red != 0))
		else report_fail("player_red differs from the model");
	a_active: assert property (@(posedge clk) disable iff (!resetN) player_active == m_active)
		else report_fail("player_active differs from the model");
	a_level: assert property (@(posedge clk) disable iff (!resetN) level == m_level)
		else report_fail("level differs from the model");
	a_speed: assert property (@(posedge clk) disable iff (!resetN)
		tree_speed == tree_speed_of(m_level) && bird_speed == m_level)
		else report_fail("speeds do not match the level");
	a_first_birds: assert property (@(posedge clk) disable iff (!resetN)
		$past(first_frame, 3) |-> deploy_bird == 2'b01)
		else report_fail("first frame birds not deployed after 3 cycles");
	a_shot_slot: assert property (@(posedge clk) disable iff (!resetN)
		|deploy_shot |-> deploy_shot == (MAX_SHOTS'(1) << m_shot_slot))
		else report_fail("deploy_shot not at the next round-robin slot");
	a_tree_slot: assert property (@(posedge clk) disable iff (!resetN)
		|deploy_tree |-> deploy_tree == (MAX_TREES'(1) << m_tree_slot))
		else report_fail("deploy_tree not at the next round-robin slot");
	a_bird_mask: assert property (@(posedge clk) disable iff (!resetN)
		|deploy_bird |-> deploy_bird == bird_mask_of(m_level))
		else report_fail("deploy_bird mask wrong for the level");
	a_shot_time: assert property (@(posedge clk) disable iff (!resetN || bp_mode)
		(|deploy_shot) == $past(shot_due, 3))
		else report_fail("shot deploy not 3 cycles after its frame");
	a_tree_time: assert property (@(posedge clk) disable iff (!resetN || bp_mode)
		(|deploy_tree) == $past(tree_due, 3))
		else report_fail("tree deploy not 3 cycles after its frame");
	a_bird_time: assert property (@(posedge clk) disable iff (!resetN || bp_mode)
		(|deploy_bird) == $past(start_due, 3))
		else report_fail("bird deploy not 3 cycles after its frame");
	a_ready_gate: assert property (@(posedge clk) disable iff (!resetN)
		((|deploy_shot) || (|deploy_tree) || (|deploy_bird)) |-> $past(deploy_ready))
		else report_fail("deploy pulse while deploy_ready was low");

	task automatic wait_frames(input int n);
		repeat (n) begin
			@(posedge clk);
			while (!sof)
				@(posedge clk);
		end
	endtask

	task automatic hit_once();
		hit_req <= 1'b1;
		wait_frames(1);
		hit_req <= 1'b0;
	endtask

	// deploys of the last frame have landed after 8 cycles
	task automatic end_test(input string name);
		repeat (8) @(posedge clk);
		assert (m_shot_deps == m_shot_reqs)
		else report_fail($sformatf("%0d shots deployed, %0d requested",
			m_shot_deps, m_shot_reqs));
		assert (m_tree_deps == m_tree_reqs)
		else report_fail($sformatf("%0d trees deployed, %0d requested",
			m_tree_deps, m_tree_reqs));
		assert (m_bird_deps == m_bird_reqs)
		else report_fail($sformatf("%0d flocks deployed, %0d requested",
			m_bird_deps, m_bird_reqs));
		tests++;
		if (errors == err_mark)
			passed++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		logic [31:0] rnd;
		int          gap_left;
		level_t      start_level;
		rnd = 32'd81;
		gap_left = 0;
		resetN = 1'b0;
		shoot = 1'b0;
		deploy_ready = 1'b1;
		hit_req = 1'b0;
		kill_birds = 1'b0;
		bp_mode = 1'b0;
		repeat (2) @(posedge clk);
		resetN <= 1'b1;

		wait_frames(2);
		end_test("reset state");

		shoot <= 1'b1;
		wait_frames(34);  // nine shots, slot 0 again
		shoot <= 1'b0;
		end_test("shots");

		repeat (2) begin
			start_level = level;
			kill_birds <= 1'b1;
			while (level == start_level)
				@(posedge clk);
			kill_birds <= 1'b0;
			wait_frames(LEVEL_DELAY + 1);
		end
		wait_frames(26);  // all level 2 trees
		end_test("levels");

		bp_mode <= 1'b1;
		repeat (640) begin
			@(posedge clk);
			rnd = lcg_next(rnd);
			shoot <= rnd[16];
			if (gap_left != 0) begin
				gap_left = gap_left - 1;
				deploy_ready <= 1'b0;
			end
			else if (rnd[22:20] == 3'd0) begin
				gap_left = int'(rnd[27:24]) % 12;
				deploy_ready <= 1'b0;
			end
			else
				deploy_ready <= 1'b1;
		end
		deploy_ready <= 1'b1;
		shoot <= 1'b0;
		wait_frames(2);
		bp_mode <= 1'b0;
		end_test("back-pressure");

		hit_once();
		wait_frames(2);
		hit_once();  // still red
		wait_frames(RED_FRAMES);
		hit_once();
		wait_frames(RED_FRAMES);
		hit_once();  // last life
		shoot <= 1'b1;
		wait_frames(10);
		shoot <= 1'b0;
		end_test("hits");

		$display("%0d tests, %0d passed, %0d failed checks", tests, passed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- list.f
common/game_pkg.sv
common/spawn_pkg.sv
game_controller/level_fsm.sv
game_controller/game_controller.sv
design/spawn_queue.sv
design/slot_allocator.sv
design/game_top.sv
testbench/game_tb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/100ps -f list.f --top-module game_tb
	out=$$(./obj_dir/Vgame_tb); echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f list.f --top-module game_top

clean:
	rm -rf obj_dir
